//--- rtl/nx_mesh_pkg.sv
package nx_mesh_pkg;

// ==============================
// Widths and sizes
// ==============================

// Full width of one mesh message
localparam int MESSAGE_WIDTH = 32;

// Mesh coordinate widths
localparam int ROW_W = 4;
localparam int COL_W = 4;

// Local data store geometry
localparam int ADDR_W      = 6;
localparam int DATA_W      = 16;
localparam int STORE_DEPTH = 64;

// ==============================
// Types
// ==============================

// Mesh coordinates
typedef logic [ROW_W-1:0] row_t;
typedef logic [COL_W-1:0] col_t;

// Node position, row in the upper half
typedef struct packed {
    row_t row;
    col_t col;
} node_id_t;

// Message commands
typedef enum logic [1:0] {
      CMD_LOAD = 2'd0
    , CMD_READ = 2'd1
    , CMD_DATA = 2'd2
} msg_cmd_t;

// Store address and word
typedef logic [ADDR_W-1:0] store_addr_t;
typedef logic [DATA_W-1:0] store_data_t;

// Whatever is left of the message after the header fields
localparam int PAYLOAD_W = MESSAGE_WIDTH - $bits(node_id_t) - $bits(msg_cmd_t) - ADDR_W;

// One message, target first
// READ carries the return node id in the top byte of the payload
typedef struct packed {
    node_id_t               target;
    msg_cmd_t               cmd;
    store_addr_t            addr;
    logic [PAYLOAD_W-1:0]   payload;
} node_message_t;

// Outbound directions, also the index into port arrays
typedef enum logic [1:0] {
      DIR_NORTH = 2'd0
    , DIR_EAST  = 2'd1
    , DIR_SOUTH = 2'd2
    , DIR_WEST  = 2'd3
} direction_t;

endpackage : nx_mesh_pkg

//--- rtl/nx_route_if.sv
`timescale 1ns/1ps

// Routed link between route select and distributor
interface nx_route_if
import nx_mesh_pkg::*;
();

    // Message and its chosen direction
    node_message_t msg;
    direction_t    dir;
    // Handshake
    logic          valid;
    logic          ready;

    // Router side
    modport source (output msg, output dir, output valid, input ready);

    // Distributor side
    modport sink (input msg, input dir, input valid, output ready);

endinterface : nx_route_if

//--- rtl/nx_inbound_arbiter.sv
`timescale 1ns/1ps

module nx_inbound_arbiter
import nx_mesh_pkg::*;
(
      input  logic                i_clk
    , input  logic                i_reset
    // Inbound streams, indexed by direction
    , input  node_message_t [3:0] i_inbound_data
    , input  logic [3:0]          i_inbound_valid
    , output logic [3:0]          o_inbound_ready
    // Arbitrated stream
    , output node_message_t       o_data
    , output logic                o_valid
    , input  logic                i_ready
    // Output register empty
    , output logic                o_idle
);

// Round robin state, search starts after the last winner
direction_t    last_q;
logic [3:0]    grant;
direction_t    grant_idx;
logic          accept;

// Output register
node_message_t data_q;
logic          valid_q;

// Room for a new message when empty or being emptied
assign accept = !valid_q || i_ready;

// First valid port after the last winner
always_comb begin : comb_grant
    logic [1:0] idx;
    logic       found;
    grant     = '0;
    grant_idx = last_q;
    found     = 1'b0;
    for (int i = 1; i <= 4; i++) begin
        // Wraps, the last winner itself is checked last
        idx = last_q + 2'(i);
        if (!found && i_inbound_valid[idx]) begin
            found      = 1'b1;
            grant[idx] = 1'b1;
            grant_idx  = direction_t'(idx);
        end
    end
end

// Only the winner sees ready
assign o_inbound_ready = accept ? grant : 4'b0000;

// Control state
always_ff @(posedge i_clk) begin
    if (i_reset) begin
        valid_q <= 1'b0;
        // North gets first look after reset
        last_q  <= DIR_WEST;
    end else if (accept) begin
        valid_q <= |i_inbound_valid;
        if (|i_inbound_valid) last_q <= grant_idx;
    end
end

// Payload capture
always_ff @(posedge i_clk) begin
    if (accept && |i_inbound_valid) data_q <= i_inbound_data[grant_idx];
end

assign o_data  = data_q;
assign o_valid = valid_q;
assign o_idle  = !valid_q;

// Never more than one inbound transfer per cycle
assert property (@(posedge i_clk) disable iff (i_reset) $onehot0(o_inbound_ready));

endmodule : nx_inbound_arbiter

//--- rtl/nx_node_decoder.sv
`timescale 1ns/1ps

module nx_node_decoder
import nx_mesh_pkg::*;
(
      input  logic          i_clk
    , input  logic          i_reset
    // This node's position
    , input  node_id_t      i_node_id
    // Arbitrated stream
    , input  node_message_t i_data
    , input  logic          i_valid
    , output logic          o_ready
    // Traffic for other nodes
    , output node_message_t o_byp_data
    , output logic          o_byp_valid
    , input  logic          i_byp_ready
    // Responses to READ
    , output node_message_t o_rsp_data
    , output logic          o_rsp_valid
    , input  logic          i_rsp_ready
    // No response pending
    , output logic          o_idle
);

// ==============================
// Address match and split
// ==============================

logic match;
logic local_ready;
logic wr_en;
logic rd_accept;

// Response register
node_message_t rsp_q;
logic          rsp_valid_q;

// Single compare feeding both paths
assign match = (i_data.target == i_node_id);

// Straight pass to bypass with ready from downstream
assign o_byp_data  = i_data;
assign o_byp_valid = i_valid && !match;

// LOAD and DATA always sink
// READ needs a free response slot
always_comb begin : comb_local_ready
    local_ready = 1'b1;
    if (i_data.cmd == CMD_READ) local_ready = !rsp_valid_q || i_rsp_ready;
end

assign o_ready = match ? local_ready : i_byp_ready;

// Local command strobes
assign wr_en     = i_valid && match && (i_data.cmd == CMD_LOAD);
assign rd_accept = i_valid && match && (i_data.cmd == CMD_READ) && local_ready;

// ==============================
// Store and response
// ==============================

store_data_t   store [STORE_DEPTH];
node_id_t      return_id;

// Return address sits in the top byte of a READ payload
assign return_id = node_id_t'(i_data.payload[PAYLOAD_W-1 -: $bits(node_id_t)]);

// LOAD write lands at the consuming edge
always_ff @(posedge i_clk) begin
    if (wr_en) store[i_data.addr] <= i_data.payload;
end

// Response valid held until taken
always_ff @(posedge i_clk) begin
    if (i_reset)          rsp_valid_q <= 1'b0;
    else if (rd_accept)   rsp_valid_q <= 1'b1;
    else if (i_rsp_ready) rsp_valid_q <= 1'b0;
end

// DATA reply keeps the address and carries the stored word
always_ff @(posedge i_clk) begin
    if (rd_accept) begin
        rsp_q.target  <= return_id;
        rsp_q.cmd     <= CMD_DATA;
        rsp_q.addr    <= i_data.addr;
        rsp_q.payload <= store[i_data.addr];
    end
end

assign o_rsp_data  = rsp_q;
assign o_rsp_valid = rsp_valid_q;
assign o_idle      = !rsp_valid_q;

// Stalled response must not move
assert property (@(posedge i_clk) disable iff (i_reset)
    (rsp_valid_q && !i_rsp_ready) |=> (rsp_valid_q && $stable(rsp_q)));

endmodule : nx_node_decoder

//--- rtl/nx_route_select.sv
`timescale 1ns/1ps

module nx_route_select
import nx_mesh_pkg::*;
(
    // This node's position and neighbour presence
      input  node_id_t      i_node_id
    , input  logic [3:0]    i_outbound_present
    // Bypass stream, higher priority
    , input  node_message_t i_byp_data
    , input  logic          i_byp_valid
    , output logic          o_byp_ready
    // Local response stream
    , input  node_message_t i_rsp_data
    , input  logic          i_rsp_valid
    , output logic          o_rsp_ready
    // Routed link to the distributor
    , nx_route_if.source    route
);

// ==============================
// Ordinal combiner
// ==============================

node_message_t merged;

// Bypass first, the response waits its turn
assign merged      = i_byp_valid ? i_byp_data : i_rsp_data;
assign route.msg   = merged;
assign route.valid = i_byp_valid || i_rsp_valid;

// Response only moves when bypass is quiet
assign o_byp_ready = route.ready;
assign o_rsp_ready = route.ready && !i_byp_valid;

// ==============================
// Direction choice
// ==============================

logic lt_row;
logic gt_row;
logic lt_col;
logic gt_col;

// Target relative to this node
assign lt_row = (merged.target.row < i_node_id.row);
assign gt_row = (merged.target.row > i_node_id.row);
assign lt_col = (merged.target.col < i_node_id.col);
assign gt_col = (merged.target.col > i_node_id.col);

// Rows first, then columns
// missing neighbour pushes to the next stream clockwise
always_comb begin : comb_dir
    if (lt_row) begin
        if (i_outbound_present[DIR_NORTH]) route.dir = DIR_NORTH;
        else                               route.dir = DIR_EAST;
    end else if (gt_row) begin
        if (i_outbound_present[DIR_SOUTH]) route.dir = DIR_SOUTH;
        else                               route.dir = DIR_WEST;
    end else if (lt_col) begin
        if (i_outbound_present[DIR_WEST])  route.dir = DIR_WEST;
        else                               route.dir = DIR_NORTH;
    end else if (gt_col) begin
        if (i_outbound_present[DIR_EAST])  route.dir = DIR_EAST;
        else                               route.dir = DIR_SOUTH;
    end else begin
        // Own address, decoder should have consumed it
        route.dir = DIR_NORTH;
    end
end

endmodule : nx_route_select

//--- rtl/nx_outbound_distributor.sv
`timescale 1ns/1ps

module nx_outbound_distributor
import nx_mesh_pkg::*;
(
      input  logic                i_clk
    , input  logic                i_reset
    // Routed link from route select
    , nx_route_if.sink            route
    // Outbound ports, indexed by direction
    , output node_message_t [3:0] o_outbound_data
    , output logic [3:0]          o_outbound_valid
    , input  logic [3:0]          i_outbound_ready
    // All registers empty
    , output logic                o_idle
);

// One register per direction
node_message_t [3:0] data_q;
logic [3:0]          valid_q;
logic [3:0]          take;
logic                sink_ready;

// Selected register is empty or draining
assign sink_ready  = !valid_q[route.dir] || i_outbound_ready[route.dir];
assign route.ready = sink_ready;

// Load strobe only for the selected direction
always_comb begin : comb_take
    take            = '0;
    take[route.dir] = route.valid && sink_ready;
end

// Valid flags
always_ff @(posedge i_clk) begin
    if (i_reset) begin
        valid_q <= '0;
    end else begin
        for (int i = 0; i < 4; i++) begin
            if (take[i])                 valid_q[i] <= 1'b1;
            else if (i_outbound_ready[i]) valid_q[i] <= 1'b0;
        end
    end
end

// Payload capture
always_ff @(posedge i_clk) begin
    for (int i = 0; i < 4; i++) begin
        if (take[i]) data_q[i] <= route.msg;
    end
end

assign o_outbound_data  = data_q;
assign o_outbound_valid = valid_q;
assign o_idle           = ~|valid_q;

// Stalled outbound data holds until the neighbour takes it
for (genvar g = 0; g < 4; g++) begin : g_hold
    assert property (@(posedge i_clk) disable iff (i_reset)
        (valid_q[g] && !i_outbound_ready[g]) |=> (valid_q[g] && $stable(data_q[g])));
end

endmodule : nx_outbound_distributor

//--- rtl/nx_mesh_node.sv
`timescale 1ns/1ps

module nx_mesh_node
import nx_mesh_pkg::*;
(
      input  logic                i_clk
    , input  logic                i_reset
    // Position in the mesh
    , input  node_id_t            i_node_id
    // Inbound ports
    , input  node_message_t [3:0] i_inbound_data
    , input  logic [3:0]          i_inbound_valid
    , output logic [3:0]          o_inbound_ready
    // Outbound ports
    , output node_message_t [3:0] o_outbound_data
    , output logic [3:0]          o_outbound_valid
    , input  logic [3:0]          i_outbound_ready
    , input  logic [3:0]          i_outbound_present
    // Nothing in flight
    , output logic                o_idle
);

// ==============================
// Internal streams
// ==============================

// Arbiter to decoder
node_message_t arb_data;
logic          arb_valid, arb_ready;

// Decoder to route select
node_message_t byp_data, rsp_data;
logic          byp_valid, byp_ready;
logic          rsp_valid, rsp_ready;

// Stage idle flags
logic arb_idle, dec_idle, dist_idle;
logic idle_q;

// Routed link
nx_route_if route_bus ();

// Low in reset, high once every stage is empty
always_ff @(posedge i_clk) begin
    if (i_reset) idle_q <= 1'b0;
    else         idle_q <= arb_idle && dec_idle && dist_idle;
end

assign o_idle = idle_q;

// ==============================
// Stages
// ==============================

nx_inbound_arbiter u_arbiter (
      .i_clk           ( i_clk           )
    , .i_reset         ( i_reset         )
    , .i_inbound_data  ( i_inbound_data  )
    , .i_inbound_valid ( i_inbound_valid )
    , .o_inbound_ready ( o_inbound_ready )
    , .o_data          ( arb_data        )
    , .o_valid         ( arb_valid       )
    , .i_ready         ( arb_ready       )
    , .o_idle          ( arb_idle        )
);

nx_node_decoder u_decoder (
      .i_clk       ( i_clk     )
    , .i_reset     ( i_reset   )
    , .i_node_id   ( i_node_id )
    , .i_data      ( arb_data  )
    , .i_valid     ( arb_valid )
    , .o_ready     ( arb_ready )
    , .o_byp_data  ( byp_data  )
    , .o_byp_valid ( byp_valid )
    , .i_byp_ready ( byp_ready )
    , .o_rsp_data  ( rsp_data  )
    , .o_rsp_valid ( rsp_valid )
    , .i_rsp_ready ( rsp_ready )
    , .o_idle      ( dec_idle  )
);

nx_route_select u_route_select (
      .i_node_id          ( i_node_id          )
    , .i_outbound_present ( i_outbound_present )
    , .i_byp_data         ( byp_data           )
    , .i_byp_valid        ( byp_valid          )
    , .o_byp_ready        ( byp_ready          )
    , .i_rsp_data         ( rsp_data           )
    , .i_rsp_valid        ( rsp_valid          )
    , .o_rsp_ready        ( rsp_ready          )
    , .route              ( route_bus          )
);

nx_outbound_distributor u_distributor (
      .i_clk            ( i_clk            )
    , .i_reset          ( i_reset          )
    , .route            ( route_bus        )
    , .o_outbound_data  ( o_outbound_data  )
    , .o_outbound_valid ( o_outbound_valid )
    , .i_outbound_ready ( i_outbound_ready )
    , .o_idle           ( dist_idle        )
);

endmodule : nx_mesh_node

//--- test/tb_nx_mesh_vectors.svh
`ifndef TB_NX_MESH_VECTORS_SVH
`define TB_NX_MESH_VECTORS_SVH

// Columns: inbound port, message, present mask, output expected,
// expected outbound port, expected outbound message
// Message hex reads as target byte, cmd and addr byte, 16-bit payload

typedef struct packed {
    direction_t    in_port;
    node_message_t msg;
    logic [3:0]    present;
    logic          expect_out;
    direction_t    out_port;
    node_message_t out_msg;
} vec_t;

// Node sits at row 5, column 5
localparam int NUM_VECTORS = 17;
localparam vec_t VECTORS [NUM_VECTORS] = '{
    // Bypass routing, every neighbour present
      '{DIR_NORTH, 32'h3581_1111, 4'b1111, 1'b1, DIR_NORTH, 32'h3581_1111}
    , '{DIR_EAST,  32'h7582_2222, 4'b1111, 1'b1, DIR_SOUTH, 32'h7582_2222}
    , '{DIR_SOUTH, 32'h5283_3333, 4'b1111, 1'b1, DIR_WEST,  32'h5283_3333}
    , '{DIR_WEST,  32'h5884_4444, 4'b1111, 1'b1, DIR_EAST,  32'h5884_4444}
    // Diagonal targets, rows decide first
    , '{DIR_EAST,  32'h3301_0f0f, 4'b1111, 1'b1, DIR_NORTH, 32'h3301_0f0f}
    , '{DIR_NORTH, 32'h7740_5566, 4'b1111, 1'b1, DIR_SOUTH, 32'h7740_5566}
    // Preferred neighbour missing, next one clockwise
    , '{DIR_SOUTH, 32'h3581_1111, 4'b1110, 1'b1, DIR_EAST,  32'h3581_1111}
    , '{DIR_WEST,  32'h7582_2222, 4'b1011, 1'b1, DIR_WEST,  32'h7582_2222}
    , '{DIR_NORTH, 32'h5283_3333, 4'b0111, 1'b1, DIR_NORTH, 32'h5283_3333}
    , '{DIR_EAST,  32'h5884_4444, 4'b1101, 1'b1, DIR_SOUTH, 32'h5884_4444}
    // Local LOADs, addresses 5, 42 and 63
    , '{DIR_NORTH, 32'h5505_abcd, 4'b1111, 1'b0, DIR_NORTH, 32'h0000_0000}
    , '{DIR_EAST,  32'h552a_1234, 4'b1111, 1'b0, DIR_NORTH, 32'h0000_0000}
    , '{DIR_WEST,  32'h553f_beef, 4'b1111, 1'b0, DIR_NORTH, 32'h0000_0000}
    // Local READs, reply goes to the return id
    , '{DIR_SOUTH, 32'h5545_2500, 4'b1111, 1'b1, DIR_NORTH, 32'h2585_abcd}
    , '{DIR_WEST,  32'h556a_5900, 4'b1111, 1'b1, DIR_EAST,  32'h59aa_1234}
    , '{DIR_NORTH, 32'h557f_5100, 4'b1111, 1'b1, DIR_WEST,  32'h51bf_beef}
    , '{DIR_EAST,  32'h5545_8500, 4'b1011, 1'b1, DIR_WEST,  32'h8585_abcd}
};

// All four inbound ports at once, one message each
localparam int NUM_BURST = 4;
localparam vec_t BURST [NUM_BURST] = '{
      '{DIR_NORTH, 32'h1591_a001, 4'b1111, 1'b1, DIR_NORTH, 32'h1591_a001}
    , '{DIR_EAST,  32'h9592_b002, 4'b1111, 1'b1, DIR_SOUTH, 32'h9592_b002}
    , '{DIR_SOUTH, 32'h5093_c003, 4'b1111, 1'b1, DIR_WEST,  32'h5093_c003}
    , '{DIR_WEST,  32'h5c94_d004, 4'b1111, 1'b1, DIR_EAST,  32'h5c94_d004}
};

`endif

//--- test/tb_nx_mesh_node.sv
`timescale 1ns/1ps

module tb_nx_mesh_node
import nx_mesh_pkg::*;
();

`include "tb_nx_mesh_vectors.svh"

// Budget of 64 cycles per presented message
localparam int WATCHDOG_CYCLES = (2 * NUM_VECTORS + 2 * NUM_BURST) * 64;

// ==============================
// DUT signals
// ==============================

logic                i_clk;
logic                i_reset;
node_id_t            i_node_id;
node_message_t [3:0] i_inbound_data;
logic [3:0]          i_inbound_valid;
logic [3:0]          o_inbound_ready;
node_message_t [3:0] o_outbound_data;
logic [3:0]          o_outbound_valid;
logic [3:0]          i_outbound_ready;
logic [3:0]          i_outbound_present;
logic                o_idle;

// Random back-pressure enable and LFSR state
logic                bp_mode;
logic [31:0]         lfsr;

// Outbound transfers seen since the last check
direction_t          cap_port [$];
node_message_t       cap_msg [$];

int                  mismatch_count;
int                  other_errors;

nx_mesh_node DUT (
      .i_clk              ( i_clk              )
    , .i_reset            ( i_reset            )
    , .i_node_id          ( i_node_id          )
    , .i_inbound_data     ( i_inbound_data     )
    , .i_inbound_valid    ( i_inbound_valid    )
    , .o_inbound_ready    ( o_inbound_ready    )
    , .o_outbound_data    ( o_outbound_data    )
    , .o_outbound_valid   ( o_outbound_valid   )
    , .i_outbound_ready   ( i_outbound_ready   )
    , .i_outbound_present ( i_outbound_present )
    , .o_idle             ( o_idle             )
);

// 4 ns period
always #2 i_clk = ~i_clk;

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// One LFSR step per ready bit
always @(posedge i_clk) begin : drive_ready
    logic [3:0] rdy;
    rdy = 4'b1111;
    if (bp_mode) begin
        for (int p = 0; p < 4; p++) begin
            lfsr   = lfsr_next(lfsr);
            rdy[p] = lfsr[0];
        end
    end
    i_outbound_ready <= rdy;
end

// Record every outbound handshake, pre-edge values
always @(posedge i_clk) begin : capture_outputs
    if (!i_reset) begin
        for (int p = 0; p < 4; p++) begin
            if (o_outbound_valid[p] && i_outbound_ready[p]) begin
                cap_port.push_back(direction_t'(p));
                cap_msg.push_back(o_outbound_data[p]);
            end
        end
    end
end

// ==============================
// Compare tasks
// ==============================

task automatic check_message(input node_message_t got, input node_message_t exp,
                             input string what);
    if (got !== exp) begin
        mismatch_count++;
        $display("Mismatch at %0t ns: %s message %h, expected %h", $time, what, got, exp);
    end
endtask

task automatic check_port(input direction_t got, input direction_t exp, input string what);
    if (got !== exp) begin
        mismatch_count++;
        $display("Mismatch at %0t ns: %s port %s, expected %s",
                 $time, what, got.name(), exp.name());
    end
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        mismatch_count++;
        $display("Mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
endtask

// ==============================
// Stimulus helpers
// ==============================

// Present one message and hold it until the handshake
task automatic send_one(input direction_t port, input node_message_t msg,
                        input logic [3:0] present);
    @(posedge i_clk);
    i_inbound_data[port]  <= msg;
    i_inbound_valid[port] <= 1'b1;
    i_outbound_present    <= present;
    @(posedge i_clk);
    while (!o_inbound_ready[port]) @(posedge i_clk);
    i_inbound_valid[port] <= 1'b0;
endtask

// Registered idle lags, give it time to fall first
task automatic wait_drain();
    repeat (2) @(posedge i_clk);
    while (!o_idle) @(posedge i_clk);
endtask

task automatic run_vector(input int i, input string tag);
    vec_t  v;
    string what;
    v    = VECTORS[i];
    what = $sformatf("%s vector %0d", tag, i);
    send_one(v.in_port, v.msg, v.present);
    wait_drain();
    if (v.expect_out) begin
        if (cap_msg.size() != 1) begin
            other_errors++;
            $display("Error at %0t ns: %s should leave once but left %0d times",
                     $time, what, cap_msg.size());
        end else begin
            check_port(cap_port[0], v.out_port, what);
            check_message(cap_msg[0], v.out_msg, what);
        end
    end else if (cap_msg.size() != 0) begin
        other_errors++;
        $display("Error at %0t ns: %s should stay in the node but produced output",
                 $time, what);
    end
    cap_msg.delete();
    cap_port.delete();
endtask

// All four inbound ports valid together
task automatic send_burst();
    logic [3:0] pending;
    pending = 4'b0000;
    @(posedge i_clk);
    for (int k = 0; k < NUM_BURST; k++) begin
        i_inbound_data[BURST[k].in_port] <= BURST[k].msg;
        pending[BURST[k].in_port] = 1'b1;
    end
    i_inbound_valid    <= pending;
    i_outbound_present <= 4'b1111;
    while (pending != 4'b0000) begin
        @(posedge i_clk);
        pending = pending & ~o_inbound_ready;
        i_inbound_valid <= pending;
    end
endtask

// Order free, each message exactly once
task automatic check_burst(input string tag);
    int hits;
    int idx;
    for (int k = 0; k < NUM_BURST; k++) begin
        hits = 0;
        idx  = 0;
        for (int c = 0; c < cap_msg.size(); c++) begin
            if (cap_msg[c] === BURST[k].out_msg) begin
                hits++;
                idx = c;
            end
        end
        if (hits != 1) begin
            other_errors++;
            $display("Error at %0t ns: %s burst message %h arrived %0d times",
                     $time, tag, BURST[k].out_msg, hits);
        end else begin
            check_port(cap_port[idx], BURST[k].out_port, $sformatf("%s burst %0d", tag, k));
        end
    end
    if (cap_msg.size() != NUM_BURST) begin
        other_errors++;
        $display("Error at %0t ns: %s burst gave %0d outputs instead of %0d",
                 $time, tag, cap_msg.size(), NUM_BURST);
    end
    cap_msg.delete();
    cap_port.delete();
endtask

// ==============================
// Main sequence
// ==============================

initial begin : main
    i_clk              = 1'b0;
    i_reset            = 1'b1;
    i_node_id          = '{row: 4'd5, col: 4'd5};
    i_inbound_data     = '0;
    i_inbound_valid    = 4'b0000;
    i_outbound_ready   = 4'b1111;
    i_outbound_present = 4'b1111;
    bp_mode            = 1'b0;
    lfsr               = 32'h9f07_68af;
    mismatch_count     = 0;
    other_errors       = 0;

    // Two reset cycles
    repeat (2) @(posedge i_clk);
    check_flag(o_idle, 1'b0, "o_idle in reset");
    i_reset <= 1'b0;
    repeat (2) @(posedge i_clk);
    check_flag(o_idle, 1'b1, "o_idle after reset");

    // Free flowing outputs
    for (int i = 0; i < NUM_VECTORS; i++) run_vector(i, "steady");
    send_burst();
    wait_drain();
    check_burst("steady");

    // Same traffic, random stalls
    bp_mode <= 1'b1;
    for (int i = 0; i < NUM_VECTORS; i++) run_vector(i, "stalled");
    send_burst();
    wait_drain();
    check_burst("stalled");

    // Everything flushed
    bp_mode <= 1'b0;
    wait_drain();
    @(posedge i_clk);
    check_flag(o_idle, 1'b1, "o_idle after drain");
    check_flag(|o_outbound_valid, 1'b0, "outbound valid after drain");

    $display("Error counts: %0d mismatches, %0d other errors", mismatch_count, other_errors);
    if (mismatch_count == 0 && other_errors == 0) begin
        $display("TESTS PASSED");
    end else begin
        $display("TESTS FAILED");
    end
    $finish;
end

// Stuck handshake ends the run
initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge i_clk);
    $display("Watchdog expired after %0d cycles, traffic did not finish", WATCHDOG_CYCLES);
    $display("TESTS FAILED");
    $finish;
end

endmodule : tb_nx_mesh_node

//--- verilog.f
+incdir+test
rtl/nx_mesh_pkg.sv
rtl/nx_route_if.sv
rtl/nx_inbound_arbiter.sv
rtl/nx_node_decoder.sv
rtl/nx_route_select.sv
rtl/nx_outbound_distributor.sv
rtl/nx_mesh_node.sv
test/tb_nx_mesh_node.sv

//--- Makefile
# Verilator build and run for the mesh node testbench

VERILATOR  ?= verilator
TOP        ?= tb_nx_mesh_node
FILELIST   ?= verilog.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
